//--- decode_execute_stage.f
dx_pkg.sv
dx_hazard_unit.sv
dx_branch_unit.sv
dx_stage_regs.sv
decode_execute_stage.sv
dx_stage_checker.sv
tb_decode_execute_stage.sv

//--- Bender.yml
package:
  name: decode_execute_stage

sources:
  - dx_pkg.sv
  - dx_hazard_unit.sv
  - dx_branch_unit.sv
  - dx_stage_regs.sv
  - decode_execute_stage.sv
  - target: test
    files:
      - dx_stage_checker.sv
      - tb_decode_execute_stage.sv

//--- tb_decode_execute_stage.sv
// Testbench for the decode to execute stage with random stimulus, reference model and compare tasks
`timescale 1ns/1ps
`default_nettype none

module tb_decode_execute_stage;

   localparam int RESET_CYCLES   = 3;
   localparam int NUM_CYCLES     = 2000;
   // One clock per random step, plus reset, the final drain and some slack
   localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_CYCLES + 97;

   logic                   clk;
   logic                   rst;
   logic                   padv_i;
   logic                   pipeline_flush_i;
   logic                   predicted_flag_i;
   dx_pkg::operand_t       pc_decode_i;
   dx_pkg::operand_t       decode_rfb_i;
   dx_pkg::operand_t       execute_rfb_i;
   dx_pkg::dx_insn_t       decode_insn_i;
   dx_pkg::dx_dec_except_t decode_except_i;
   dx_pkg::dx_ctrl_state_t ctrl_state_i;
   dx_pkg::dx_insn_t       execute_insn_o;
   dx_pkg::dx_exe_except_t execute_except_o;
   dx_pkg::operand_t       pc_execute_o;
   dx_pkg::operand_t       execute_jal_result_o;
   dx_pkg::operand_t       execute_mispredict_target_o;
   logic                   execute_predicted_flag_o;
   logic                   decode_valid_o;
   logic                   execute_bubble_o;
   logic                   decode_bubble_o;
   logic                   decode_branch_o;
   dx_pkg::operand_t       decode_branch_target_o;

   // Shadow execute registers
   dx_pkg::dx_insn_t       exp_insn;
   dx_pkg::dx_exe_except_t exp_except;
   dx_pkg::operand_t       exp_pc;
   dx_pkg::operand_t       exp_jal;
   dx_pkg::operand_t       exp_mispredict;
   logic                   exp_pred_flag;
   logic                   exp_valid;
   logic                   exp_exe_bubble;
   logic                   payload_known;
   logic                   brcond_known;
   // Model results for the decode inputs of the current cycle
   logic                   m_bubble;
   logic                   m_branch;
   logic                   m_align;
   dx_pkg::operand_t       m_target;
   dx_pkg::operand_t       m_mispredict;
   int                     step;
   int                     cycle_count;

   decode_execute_stage #(
      .PIPELINED_MUL (1'b1),
      .DELAY_SLOT    (1'b1)
   ) i_decode_execute_stage (
      .clk                         (clk),
      .rst                         (rst),
      .padv_i                      (padv_i),
      .pipeline_flush_i            (pipeline_flush_i),
      .pc_decode_i                 (pc_decode_i),
      .predicted_flag_i            (predicted_flag_i),
      .decode_rfb_i                (decode_rfb_i),
      .execute_rfb_i               (execute_rfb_i),
      .decode_insn_i               (decode_insn_i),
      .decode_except_i             (decode_except_i),
      .ctrl_state_i                (ctrl_state_i),
      .execute_insn_o              (execute_insn_o),
      .execute_except_o            (execute_except_o),
      .pc_execute_o                (pc_execute_o),
      .execute_jal_result_o        (execute_jal_result_o),
      .execute_mispredict_target_o (execute_mispredict_target_o),
      .execute_predicted_flag_o    (execute_predicted_flag_o),
      .decode_valid_o              (decode_valid_o),
      .execute_bubble_o            (execute_bubble_o),
      .decode_bubble_o             (decode_bubble_o),
      .decode_branch_o             (decode_branch_o),
      .decode_branch_target_o      (decode_branch_target_o)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic report_mismatch(string name, string exp_s, string act_s);
      $display("CHECK FAILED %s (step %0d): expected %s, actual %s", name, step, exp_s, act_s);
      $display("Simulation FAILED");
      $fatal(1, "value mismatch");
   endtask

   task automatic check_insn(string name, dx_pkg::dx_insn_t exp, dx_pkg::dx_insn_t act);
      if (act !== exp) report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
   endtask

   task automatic check_except(string name, dx_pkg::dx_exe_except_t exp,
                               dx_pkg::dx_exe_except_t act);
      if (act !== exp) report_mismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
   endtask

   task automatic check_operand(string name, dx_pkg::operand_t exp, dx_pkg::operand_t act);
      if (act !== exp) report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
   endtask

   task automatic check_bit(string name, logic exp, logic act);
      if (act !== exp) report_mismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
   endtask

   // Payload fields have no reset value, so only ops and opcode are compared before a load
   function automatic dx_pkg::dx_insn_t clear_payload(dx_pkg::dx_insn_t insn);
      dx_pkg::dx_insn_t kept;
      kept          = '0;
      kept.ops      = insn.ops;
      kept.opc_insn = insn.opc_insn;
      return kept;
   endfunction

   task automatic drive_random();
      logic [18:0] flag_bits;
      int unsigned word;
      for (int i = 0; i < 19; i++) flag_bits[i] = (($urandom % 8) == 0);
      decode_insn_i.ops          = dx_pkg::dx_ops_t'(flag_bits);
      decode_insn_i.opc_alu      = 4'($urandom);
      decode_insn_i.opc_insn     = 6'($urandom);
      decode_insn_i.imm16        = 16'($urandom);
      decode_insn_i.immjbr_upper = 10'($urandom);
      // Few register numbers so that hazards come up often
      decode_insn_i.rfd_adr      = 5'($urandom % 4);
      decode_insn_i.rfa_adr      = 5'($urandom % 4);
      decode_insn_i.rfb_adr      = 5'($urandom % 4);
      decode_except_i = dx_pkg::dx_dec_except_t'(4'($urandom) & 4'($urandom) & 4'($urandom));
      ctrl_state_i.rfd_adr     = 5'($urandom % 4);
      ctrl_state_i.op_lsu_load = (($urandom % 6) == 0);
      ctrl_state_i.op_mfspr    = (($urandom % 6) == 0);
      ctrl_state_i.op_mul      = (($urandom % 6) == 0);
      word = $urandom;
      if (($urandom % 8) != 0) word[1:0] = 2'b00;
      pc_decode_i = word;
      word = $urandom;
      if (($urandom % 4) != 0) word[1:0] = 2'b00;
      decode_rfb_i = word;
      word = $urandom;
      if (($urandom % 4) != 0) word[1:0] = 2'b00;
      execute_rfb_i = word;
      predicted_flag_i = 1'($urandom);
      padv_i           = (($urandom % 4) != 0);
      pipeline_flush_i = (($urandom % 20) == 0);
   endtask

   task automatic compute_model();
      logic             ctrl_il;
      logic             exe_match;
      logic             jr_haz;
      logic             imm_taken;
      dx_pkg::operand_t imm_tgt;
      ctrl_il = (ctrl_state_i.op_lsu_load || ctrl_state_i.op_mfspr || ctrl_state_i.op_mul) &&
                ((decode_insn_i.rfa_adr == ctrl_state_i.rfd_adr) ||
                 (decode_insn_i.rfb_adr == ctrl_state_i.rfd_adr));
      exe_match = (decode_insn_i.rfa_adr == exp_insn.rfd_adr) ||
                  (decode_insn_i.rfb_adr == exp_insn.rfd_adr);
      jr_haz = ctrl_il || (exp_insn.ops.rf_wb && (decode_insn_i.rfb_adr == exp_insn.rfd_adr));
      m_bubble = padv_i &&
         (((exp_insn.ops.op_lsu_load || exp_insn.ops.op_mfspr || exp_insn.ops.op_mul) &&
           exe_match) ||
          (decode_insn_i.ops.op_mul && (ctrl_il || (exp_insn.ops.rf_wb && exe_match))) ||
          (decode_insn_i.ops.op_jr && jr_haz) ||
          (exp_insn.ops.op_lsu_store && exp_insn.ops.op_lsu_atomic) ||
          decode_insn_i.ops.op_rfe);
      imm_taken = decode_insn_i.ops.op_jbr && ((decode_insn_i.opc_insn[2:1] == 2'b00) ||
                                               (decode_insn_i.opc_insn[2] == predicted_flag_i));
      imm_tgt = pc_decode_i + {{4{decode_insn_i.immjbr_upper[9]}}, decode_insn_i.immjbr_upper,
                               decode_insn_i.imm16, 2'b00};
      m_branch = (imm_taken || (decode_insn_i.ops.op_jr && !jr_haz)) && !pipeline_flush_i;
      if (imm_taken) m_target = imm_tgt;
      else if (exp_exe_bubble || exp_insn.ops.op_jr) m_target = execute_rfb_i;
      else m_target = decode_rfb_i;
      m_align = m_branch && (m_target[1:0] != 2'b00);
      m_mispredict = ((decode_insn_i.ops.op_bf && !predicted_flag_i) ||
                      (decode_insn_i.ops.op_bnf && predicted_flag_i)) ? imm_tgt : pc_decode_i + 8;
   endtask

   // Mirrors one rising edge of the execute registers
   task automatic update_model();
      if (pipeline_flush_i) begin
         exp_insn.ops      = '0;
         exp_insn.opc_insn = dx_pkg::OPCODE_NOP;
         exp_exe_bubble    = 1'b0;
      end else if (padv_i) begin
         exp_insn.ops      = m_bubble ? '0 : decode_insn_i.ops;
         exp_insn.ops.op_rfe = decode_insn_i.ops.op_rfe;
         exp_insn.opc_insn = m_bubble ? dx_pkg::OPCODE_NOP : decode_insn_i.opc_insn;
         exp_exe_bubble    = m_bubble;
      end
      if (padv_i) begin
         exp_insn.opc_alu      = decode_insn_i.opc_alu;
         exp_insn.imm16        = decode_insn_i.imm16;
         exp_insn.immjbr_upper = decode_insn_i.immjbr_upper;
         exp_insn.rfd_adr      = decode_insn_i.rfd_adr;
         exp_insn.rfa_adr      = decode_insn_i.rfa_adr;
         exp_insn.rfb_adr      = decode_insn_i.rfb_adr;
         exp_except.dec        = decode_except_i;
         exp_except.ibus_align = m_align;
         exp_pc                = pc_decode_i;
         exp_jal               = pc_decode_i + 8;
         payload_known         = 1'b1;
         if (decode_insn_i.ops.op_brcond) begin
            exp_mispredict = m_mispredict;
            exp_pred_flag  = predicted_flag_i;
            brcond_known   = 1'b1;
         end
      end
      exp_valid = padv_i;
   endtask

   task automatic check_registered();
      dx_pkg::dx_insn_t exp_view;
      dx_pkg::dx_insn_t act_view;
      exp_view = payload_known ? exp_insn : clear_payload(exp_insn);
      act_view = payload_known ? execute_insn_o : clear_payload(execute_insn_o);
      check_insn("execute_insn", exp_view, act_view);
      check_except("execute_except", exp_except, execute_except_o);
      if (payload_known) begin
         check_operand("pc_execute", exp_pc, pc_execute_o);
         check_operand("execute_jal_result", exp_jal, execute_jal_result_o);
      end
      if (brcond_known) begin
         check_operand("execute_mispredict_target", exp_mispredict, execute_mispredict_target_o);
         check_bit("execute_predicted_flag", exp_pred_flag, execute_predicted_flag_o);
      end
      check_bit("decode_valid", exp_valid, decode_valid_o);
      check_bit("execute_bubble", exp_exe_bubble, execute_bubble_o);
   endtask

   initial begin
      cycle_count = 0;
      forever begin
         @(posedge clk);
         cycle_count++;
         if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
         end
      end
   end

   initial begin
      void'($urandom(70));
      rst = 1'b1;
      padv_i = 1'b0;
      pipeline_flush_i = 1'b0;
      predicted_flag_i = 1'b0;
      pc_decode_i = '0;
      decode_rfb_i = '0;
      execute_rfb_i = '0;
      decode_insn_i = '0;
      decode_except_i = '0;
      ctrl_state_i = '0;
      step = 0;
      exp_insn = '0;
      exp_insn.opc_insn = dx_pkg::OPCODE_NOP;
      exp_except = '0;
      exp_valid = 1'b0;
      exp_exe_bubble = 1'b0;
      payload_known = 1'b0;
      brcond_known = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      check_registered();
      for (step = 1; step <= NUM_CYCLES; step++) begin
         drive_random();
         #1;
         compute_model();
         check_bit("decode_bubble", m_bubble, decode_bubble_o);
         check_bit("decode_branch", m_branch, decode_branch_o);
         check_operand("decode_branch_target", m_target, decode_branch_target_o);
         @(posedge clk);
         update_model();
         @(negedge clk);
         check_registered();
      end
      // One more edge so the last bound assertions are evaluated
      padv_i = 1'b0;
      pipeline_flush_i = 1'b0;
      @(posedge clk);
      @(negedge clk);
      if (i_decode_execute_stage.i_dx_stage_checker.fail_count == 0) begin
         $display("Simulation PASSED");
         $finish;
      end else begin
         $display("Bound assertions failed %0d times",
                  i_decode_execute_stage.i_dx_stage_checker.fail_count);
         $display("Simulation FAILED");
         $fatal(1, "assertion failures");
      end
   end

endmodule

`default_nettype wire

//--- dx_stage_checker.sv
// Bound assertions on reset values, flush clearing, hold and bubble insertion
`timescale 1ns/1ps
`default_nettype none

module dx_stage_checker (
   input wire                    clk,
   input wire                    rst,
   input wire                    padv_i,
   input wire                    pipeline_flush_i,
   input wire                    decode_bubble_i,
   input dx_pkg::dx_insn_t       execute_insn_i,
   input dx_pkg::dx_exe_except_t execute_except_i,
   input wire                    decode_valid_i,
   input wire                    execute_bubble_i
);

   int unsigned fail_count = 0;

   reset_values_a: assert property (@(posedge clk)
      rst |=> (execute_insn_i.ops == '0) && (execute_insn_i.opc_insn == dx_pkg::OPCODE_NOP) &&
              (execute_except_i == '0) && !decode_valid_i && !execute_bubble_i)
      else begin
         fail_count++;
         $error("execute registers not at reset values after reset");
      end

   // Flush wins over advance
   flush_clear_a: assert property (@(posedge clk) disable iff (rst)
      pipeline_flush_i |=> (execute_insn_i.ops == '0) &&
                           (execute_insn_i.opc_insn == dx_pkg::OPCODE_NOP) && !execute_bubble_i)
      else begin
         fail_count++;
         $error("execute ops not cleared after flush");
      end

   hold_a: assert property (@(posedge clk) disable iff (rst)
      !padv_i && !pipeline_flush_i |=> $stable(execute_insn_i.ops) &&
         $stable(execute_insn_i.opc_insn) && $stable(execute_except_i) &&
         $stable(execute_bubble_i) && !decode_valid_i)
      else begin
         fail_count++;
         $error("execute registers changed without advance");
      end

   bubble_a: assert property (@(posedge clk) disable iff (rst)
      padv_i && decode_bubble_i && !pipeline_flush_i |=>
         execute_bubble_i && (execute_insn_i.opc_insn == dx_pkg::OPCODE_NOP))
      else begin
         fail_count++;
         $error("bubble not inserted into execute");
      end

endmodule

bind decode_execute_stage dx_stage_checker i_dx_stage_checker (
   .clk              (clk),
   .rst              (rst),
   .padv_i           (padv_i),
   .pipeline_flush_i (pipeline_flush_i),
   .decode_bubble_i  (decode_bubble_o),
   .execute_insn_i   (execute_insn_o),
   .execute_except_i (execute_except_o),
   .decode_valid_i   (decode_valid_o),
   .execute_bubble_i (execute_bubble_o)
);

`default_nettype wire

//--- decode_execute_stage.sv
// Decode to execute stage top: hazard unit, branch unit and stage registers
`timescale 1ns/1ps
`default_nettype none

module decode_execute_stage #(
   parameter bit PIPELINED_MUL = 1'b1,
   parameter bit DELAY_SLOT    = 1'b1
) (
   input  wire                    clk,
   input  wire                    rst,
   input  wire                    padv_i,
   input  wire                    pipeline_flush_i,
   input  dx_pkg::operand_t       pc_decode_i,
   input  wire                    predicted_flag_i,
   input  dx_pkg::operand_t       decode_rfb_i,
   input  dx_pkg::operand_t       execute_rfb_i,
   input  dx_pkg::dx_insn_t       decode_insn_i,
   input  dx_pkg::dx_dec_except_t decode_except_i,
   input  dx_pkg::dx_ctrl_state_t ctrl_state_i,
   output dx_pkg::dx_insn_t       execute_insn_o,
   output dx_pkg::dx_exe_except_t execute_except_o,
   output dx_pkg::operand_t       pc_execute_o,
   output dx_pkg::operand_t       execute_jal_result_o,
   output dx_pkg::operand_t       execute_mispredict_target_o,
   output logic                   execute_predicted_flag_o,
   output logic                   decode_valid_o,
   output logic                   execute_bubble_o,
   output logic                   decode_bubble_o,
   output logic                   decode_branch_o,
   output dx_pkg::operand_t       decode_branch_target_o
);

   dx_pkg::dx_exe_state_t exe_state;
   logic                  jr_hazard;
   logic                  ibus_align;
   dx_pkg::operand_t      mispredict_target;
   dx_pkg::operand_t      jal_result;

   dx_hazard_unit #(
      .PIPELINED_MUL (PIPELINED_MUL)
   ) i_dx_hazard_unit (
      .padv_i          (padv_i),
      .decode_insn_i   (decode_insn_i),
      .exe_state_i     (exe_state),
      .ctrl_state_i    (ctrl_state_i),
      .decode_bubble_o (decode_bubble_o),
      .jr_hazard_o     (jr_hazard)
   );

   dx_branch_unit #(
      .DELAY_SLOT (DELAY_SLOT)
   ) i_dx_branch_unit (
      .pc_decode_i         (pc_decode_i),
      .decode_insn_i       (decode_insn_i),
      .predicted_flag_i    (predicted_flag_i),
      .jr_hazard_i         (jr_hazard),
      .pipeline_flush_i    (pipeline_flush_i),
      .exe_state_i         (exe_state),
      .decode_rfb_i        (decode_rfb_i),
      .execute_rfb_i       (execute_rfb_i),
      .branch_o            (decode_branch_o),
      .branch_target_o     (decode_branch_target_o),
      .ibus_align_o        (ibus_align),
      .mispredict_target_o (mispredict_target),
      .jal_result_o        (jal_result)
   );

   // Registers also return the execute view used by both units above
   dx_stage_regs i_dx_stage_regs (
      .clk                         (clk),
      .rst                         (rst),
      .padv_i                      (padv_i),
      .pipeline_flush_i            (pipeline_flush_i),
      .decode_bubble_i             (decode_bubble_o),
      .decode_insn_i               (decode_insn_i),
      .decode_except_i             (decode_except_i),
      .pc_decode_i                 (pc_decode_i),
      .predicted_flag_i            (predicted_flag_i),
      .ibus_align_i                (ibus_align),
      .mispredict_target_i         (mispredict_target),
      .jal_result_i                (jal_result),
      .execute_insn_o              (execute_insn_o),
      .execute_except_o            (execute_except_o),
      .pc_execute_o                (pc_execute_o),
      .execute_jal_result_o        (execute_jal_result_o),
      .execute_mispredict_target_o (execute_mispredict_target_o),
      .execute_predicted_flag_o    (execute_predicted_flag_o),
      .decode_valid_o              (decode_valid_o),
      .execute_bubble_o            (execute_bubble_o),
      .exe_state_o                 (exe_state)
   );

endmodule

`default_nettype wire

//--- dx_stage_regs.sv
// Decode to execute pipeline registers with flush and bubble clearing
`timescale 1ns/1ps
`default_nettype none

module dx_stage_regs (
   input  wire                    clk,
   input  wire                    rst,
   input  wire                    padv_i,
   input  wire                    pipeline_flush_i,
   input  wire                    decode_bubble_i,
   input  dx_pkg::dx_insn_t       decode_insn_i,
   input  dx_pkg::dx_dec_except_t decode_except_i,
   input  dx_pkg::operand_t       pc_decode_i,
   input  wire                    predicted_flag_i,
   input  wire                    ibus_align_i,
   input  dx_pkg::operand_t       mispredict_target_i,
   input  dx_pkg::operand_t       jal_result_i,
   output dx_pkg::dx_insn_t       execute_insn_o,
   output dx_pkg::dx_exe_except_t execute_except_o,
   output dx_pkg::operand_t       pc_execute_o,
   output dx_pkg::operand_t       execute_jal_result_o,
   output dx_pkg::operand_t       execute_mispredict_target_o,
   output logic                   execute_predicted_flag_o,
   output logic                   decode_valid_o,
   output logic                   execute_bubble_o,
   output dx_pkg::dx_exe_state_t  exe_state_o
);

   dx_pkg::dx_ops_t          ops_q;
   dx_pkg::dx_ops_t          bubble_ops;
   dx_pkg::opc_insn_t        opc_insn_q;
   logic [dx_pkg::ALU_OPC_WIDTH-1:0] opc_alu_q;
   dx_pkg::imm16_t           imm16_q;
   dx_pkg::immjbr_upper_t    immjbr_upper_q;
   dx_pkg::rf_adr_t          rfd_adr_q;
   dx_pkg::rf_adr_t          rfa_adr_q;
   dx_pkg::rf_adr_t          rfb_adr_q;

   // A bubble keeps rfe so it still reaches control and raises its flush
   always_comb begin
      bubble_ops = '0;
      bubble_ops.op_rfe = decode_insn_i.ops.op_rfe;
   end

   // Op flags, writeback enable, major opcode and bubble flag
   always_ff @(posedge clk) begin
      if (rst || pipeline_flush_i) begin
         ops_q            <= '0;
         opc_insn_q       <= dx_pkg::OPCODE_NOP;
         execute_bubble_o <= 1'b0;
      end else if (padv_i) begin
         ops_q            <= decode_bubble_i ? bubble_ops : decode_insn_i.ops;
         opc_insn_q       <= decode_bubble_i ? dx_pkg::OPCODE_NOP : decode_insn_i.opc_insn;
         execute_bubble_o <= decode_bubble_i;
      end
   end

   // Exceptions load on advance even during a flush
   always_ff @(posedge clk) begin
      if (rst) begin
         execute_except_o <= '0;
      end else if (padv_i) begin
         execute_except_o.dec        <= decode_except_i;
         execute_except_o.ibus_align <= ibus_align_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         decode_valid_o <= 1'b0;
      end else begin
         decode_valid_o <= padv_i;
      end
   end

   // Payload fields
   always_ff @(posedge clk) begin
      if (padv_i) begin
         opc_alu_q            <= decode_insn_i.opc_alu;
         imm16_q              <= decode_insn_i.imm16;
         immjbr_upper_q       <= decode_insn_i.immjbr_upper;
         rfd_adr_q            <= decode_insn_i.rfd_adr;
         rfa_adr_q            <= decode_insn_i.rfa_adr;
         rfb_adr_q            <= decode_insn_i.rfb_adr;
         pc_execute_o         <= pc_decode_i;
         execute_jal_result_o <= jal_result_i;
      end
   end

   // Prediction state only matters for conditional branches
   always_ff @(posedge clk) begin
      if (padv_i && decode_insn_i.ops.op_brcond) begin
         execute_mispredict_target_o <= mispredict_target_i;
         execute_predicted_flag_o    <= predicted_flag_i;
      end
   end

   always_comb begin
      execute_insn_o.ops          = ops_q;
      execute_insn_o.opc_alu      = opc_alu_q;
      execute_insn_o.opc_insn     = opc_insn_q;
      execute_insn_o.imm16        = imm16_q;
      execute_insn_o.immjbr_upper = immjbr_upper_q;
      execute_insn_o.rfd_adr      = rfd_adr_q;
      execute_insn_o.rfa_adr      = rfa_adr_q;
      execute_insn_o.rfb_adr      = rfb_adr_q;
   end

   // Execute view for hazard detection and jr target selection
   always_comb begin
      exe_state_o.rfd_adr       = rfd_adr_q;
      exe_state_o.rf_wb         = ops_q.rf_wb;
      exe_state_o.op_lsu_load   = ops_q.op_lsu_load;
      exe_state_o.op_mfspr      = ops_q.op_mfspr;
      exe_state_o.op_mul        = ops_q.op_mul;
      exe_state_o.op_lsu_store  = ops_q.op_lsu_store;
      exe_state_o.op_lsu_atomic = ops_q.op_lsu_atomic;
      exe_state_o.op_jr         = ops_q.op_jr;
      exe_state_o.bubble        = execute_bubble_o;
   end

endmodule

`default_nettype wire

//--- dx_branch_unit.sv
// Branch resolution in decode: targets, mispredict target, link result, alignment check
`timescale 1ns/1ps
`default_nettype none

module dx_branch_unit #(
   parameter bit DELAY_SLOT = 1'b1
) (
   input  dx_pkg::operand_t      pc_decode_i,
   input  dx_pkg::dx_insn_t      decode_insn_i,
   input  wire                   predicted_flag_i,
   input  wire                   jr_hazard_i,
   input  wire                   pipeline_flush_i,
   input  dx_pkg::dx_exe_state_t exe_state_i,
   input  dx_pkg::operand_t      decode_rfb_i,
   input  dx_pkg::operand_t      execute_rfb_i,
   output logic                  branch_o,
   output dx_pkg::operand_t      branch_target_o,
   output logic                  ibus_align_o,
   output dx_pkg::operand_t      mispredict_target_o,
   output dx_pkg::operand_t      jal_result_o
);

   logic             branch_to_imm;
   logic             branch_to_reg;
   dx_pkg::operand_t imm_offset;
   dx_pkg::operand_t imm_target;
   dx_pkg::operand_t reg_target;
   dx_pkg::operand_t next_pc;

   // l.j and l.jal always, l.bf and l.bnf when the predicted flag agrees
   assign branch_to_imm = decode_insn_i.ops.op_jbr &
                          (~|decode_insn_i.opc_insn[2:1] |
                           (decode_insn_i.opc_insn[2] == predicted_flag_i));

   // Word offset, sign extended from the top of the jump field
   assign imm_offset = {{(dx_pkg::OPERAND_WIDTH-28){decode_insn_i.immjbr_upper[9]}},
                        decode_insn_i.immjbr_upper,
                        decode_insn_i.imm16,
                        2'b00};

   assign imm_target = pc_decode_i + imm_offset;

   assign branch_to_reg = decode_insn_i.ops.op_jr & ~jr_hazard_i;

   // After a bubble the jr source value comes out of the execute bypass
   assign reg_target = (exe_state_i.bubble | exe_state_i.op_jr) ?
                       execute_rfb_i : decode_rfb_i;

   assign branch_o = (branch_to_imm | branch_to_reg) & ~pipeline_flush_i;

   assign branch_target_o = branch_to_imm ? imm_target : reg_target;

   assign ibus_align_o = branch_o & (|branch_target_o[1:0]);

   // Return address skips the delay slot when there is one
   assign next_pc = DELAY_SLOT ? pc_decode_i + dx_pkg::OPERAND_WIDTH'(8) :
                                 pc_decode_i + dx_pkg::OPERAND_WIDTH'(4);

   // Where to go if the predicted flag turns out wrong
   assign mispredict_target_o =
      ((decode_insn_i.ops.op_bf & ~predicted_flag_i) |
       (decode_insn_i.ops.op_bnf & predicted_flag_i)) ? imm_target : next_pc;

   assign jal_result_o = next_pc;

endmodule

`default_nettype wire

//--- dx_hazard_unit.sv
// Interlock and bubble detection against the execute and control stages
`timescale 1ns/1ps
`default_nettype none

module dx_hazard_unit #(
   parameter bit PIPELINED_MUL = 1'b1
) (
   input  wire                    padv_i,
   input  dx_pkg::dx_insn_t       decode_insn_i,
   input  dx_pkg::dx_exe_state_t  exe_state_i,
   input  dx_pkg::dx_ctrl_state_t ctrl_state_i,
   output logic                   decode_bubble_o,
   output logic                   jr_hazard_o
);

   logic ctrl_interlock;
   logic exe_src_match;
   logic exe_wb_rfb;
   logic exe_late_result;
   logic mul_hazard;

   // Control stage result arrives too late for a decode source operand
   assign ctrl_interlock = (ctrl_state_i.op_lsu_load | ctrl_state_i.op_mfspr |
                            (ctrl_state_i.op_mul & PIPELINED_MUL)) &
                           ((decode_insn_i.rfa_adr == ctrl_state_i.rfd_adr) ||
                            (decode_insn_i.rfb_adr == ctrl_state_i.rfd_adr));

   assign exe_src_match = (decode_insn_i.rfa_adr == exe_state_i.rfd_adr) ||
                          (decode_insn_i.rfb_adr == exe_state_i.rfd_adr);

   assign exe_wb_rfb = exe_state_i.rf_wb &
                       (decode_insn_i.rfb_adr == exe_state_i.rfd_adr);

   // Execute holds an op whose result only exists in control
   assign exe_late_result = (exe_state_i.op_lsu_load | exe_state_i.op_mfspr |
                             (exe_state_i.op_mul & PIPELINED_MUL)) & exe_src_match;

   // Pipelined multiplier reads operands one stage early
   assign mul_hazard = PIPELINED_MUL & decode_insn_i.ops.op_mul &
                       (ctrl_interlock | (exe_state_i.rf_wb & exe_src_match));

   // jr target register not yet written back
   assign jr_hazard_o = ctrl_interlock | exe_wb_rfb;

   // rfe also bubbles, holding fetch while it travels to control
   assign decode_bubble_o = (exe_late_result |
                             mul_hazard |
                             (decode_insn_i.ops.op_jr & jr_hazard_o) |
                             (exe_state_i.op_lsu_store & exe_state_i.op_lsu_atomic) |
                             decode_insn_i.ops.op_rfe) & padv_i;

endmodule

`default_nettype wire

//--- dx_pkg.sv
// Widths, field types, NOP opcode and structs for the decode to execute stage
`default_nettype none

package dx_pkg;

   // Data path and field widths
   localparam int OPERAND_WIDTH  = 32;
   localparam int RF_ADDR_WIDTH  = 5;
   localparam int OPC_INSN_WIDTH = 6;
   localparam int ALU_OPC_WIDTH  = 4;

   typedef logic [OPERAND_WIDTH-1:0]  operand_t;
   typedef logic [RF_ADDR_WIDTH-1:0]  rf_adr_t;
   typedef logic [15:0]               imm16_t;
   typedef logic [9:0]                immjbr_upper_t;
   typedef logic [OPC_INSN_WIDTH-1:0] opc_insn_t;

   // Major opcode placed in execute on reset, flush or bubble
   localparam opc_insn_t OPCODE_NOP = 6'h05;

   // Operation flags plus register writeback enable
   typedef struct packed {
      logic rf_wb;
      logic op_alu;
      logic op_add;
      logic op_mul;
      logic op_div;
      logic op_shift;
      logic op_setflag;
      logic op_jbr;
      logic op_jr;
      logic op_jal;
      logic op_bf;
      logic op_bnf;
      logic op_brcond;
      logic op_lsu_load;
      logic op_lsu_store;
      logic op_lsu_atomic;
      logic op_mfspr;
      logic op_mtspr;
      logic op_rfe;
   } dx_ops_t;

   // One decoded instruction as it moves from decode into execute
   typedef struct packed {
      dx_ops_t                  ops;
      logic [ALU_OPC_WIDTH-1:0] opc_alu;
      opc_insn_t                opc_insn;
      imm16_t                   imm16;
      immjbr_upper_t            immjbr_upper;
      rf_adr_t                  rfd_adr;
      rf_adr_t                  rfa_adr;
      rf_adr_t                  rfb_adr;
   } dx_insn_t;

   // Exceptions raised by fetch and decode
   typedef struct packed {
      logic ibus_err;
      logic illegal;
      logic syscall;
      logic trap;
   } dx_dec_except_t;

   // Decode exceptions plus the branch target alignment fault
   typedef struct packed {
      dx_dec_except_t dec;
      logic           ibus_align;
   } dx_exe_except_t;

   // Instruction in the control stage, for the interlock
   typedef struct packed {
      rf_adr_t rfd_adr;
      logic    op_lsu_load;
      logic    op_mfspr;
      logic    op_mul;
   } dx_ctrl_state_t;

   // Instruction in the execute registers, fed back for hazards and jr target
   typedef struct packed {
      rf_adr_t rfd_adr;
      logic    rf_wb;
      logic    op_lsu_load;
      logic    op_mfspr;
      logic    op_mul;
      logic    op_lsu_store;
      logic    op_lsu_atomic;
      logic    op_jr;
      logic    bubble;
   } dx_exe_state_t;

endpackage

`default_nettype wire
